//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_softint_unit
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

# build, run, and pass only when the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/softint_check.sv
`timescale 1ns/1ps
`default_nettype none

// merges both register parts into full softint words
// and flags per-thread differences against the observed register
module softint_check import softint_pkg::*; #(
  parameter int NUM_THREADS = 4
) (
  input  logic                               rtl_clk,
  input  logic                               rtl_reset,
  input  sw_field_t                          sw_field [NUM_THREADS],
  input  logic [NUM_THREADS-1:0][NUM_EV-1:0] event_bits,
  input  logic [NUM_THREADS*SOFTINT_W-1:0]   observed,   // flattened, thread 0 low
  input  logic                               check_en,
  output logic [NUM_THREADS*SOFTINT_W-1:0]   expected,   // flattened, thread 0 low
  output logic [NUM_THREADS-1:0]             mismatch
);

  // ==================================================
  // expected word assembly
  // ==================================================
  softint_t exp_word [NUM_THREADS];

  always_comb begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      exp_word[t]              = '0;
      exp_word[t][SW_HI:SW_LO] = sw_field[t];
      for (int e = 0; e < NUM_EV; e++) begin
        exp_word[t][EV_POS[e]] = event_bits[t][e];  // tick, pic, stick
      end
    end
  end

  for (genvar t = 0; t < NUM_THREADS; t++) begin : g_exp
    assign expected[t*SOFTINT_W +: SOFTINT_W] = exp_word[t];
  end

  // ==================================================
  // mismatch flags, one cycle after the sample
  // ==================================================
  always_ff @(posedge rtl_clk) begin
    if (rtl_reset) begin
      mismatch <= '0;  // no flags during reset
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        // compare against the state held before this edge
        mismatch[t] <= check_en &&
                       (observed[t*SOFTINT_W +: SOFTINT_W] != exp_word[t]);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/softint_event_bits.sv
`timescale 1ns/1ps
`default_nettype none

// event bits 0, 15 and 16 of the softint register, per thread
// each bit has its own enable and its own hardware source
module softint_event_bits import softint_pkg::*; #(
  parameter int NUM_THREADS = 4
) (
  input  logic                   rtl_clk,
  input  logic                   rtl_reset,
  softint_wr_if.sink             wr,
  input  logic [NUM_THREADS-1:0] tick_en,    // bit 0 enable
  input  logic [NUM_THREADS-1:0] pic_en,     // bit 15 enable
  input  logic [NUM_THREADS-1:0] stick_en,   // bit 16 enable
  input  logic [NUM_THREADS-1:0] tick_int,   // tick compare hit
  input  logic [NUM_THREADS-1:0] stick_int,  // system tick compare hit
  input  logic [NUM_THREADS-1:0] picl_wrap,  // low counter wrap
  input  logic [NUM_THREADS-1:0] pich_wrap,  // high counter wrap
  output logic [NUM_THREADS-1:0][NUM_EV-1:0] event_bits
);

  // ==================================================
  // per-slot enables and sources
  // ==================================================
  // slot order follows EV_POS: tick, pic, stick
  logic [NUM_THREADS-1:0][NUM_EV-1:0] ev_en;
  logic [NUM_THREADS-1:0][NUM_EV-1:0] ev_src;

  for (genvar t = 0; t < NUM_THREADS; t++) begin : g_thr
    assign ev_en[t]  = {stick_en[t], pic_en[t], tick_en[t]};
    // either counter wrap raises the pic bit
    assign ev_src[t] = {stick_int[t], picl_wrap[t] | pich_wrap[t], tick_int[t]};
  end

  // ==================================================
  // strobe decode
  // ==================================================
  logic do_wr;
  logic do_set;
  logic do_clr;

  assign do_wr  = ~wr.wr_l;                       // write wins
  assign do_set = wr.wr_l & ~wr.set_l;            // then set
  assign do_clr = wr.wr_l & wr.set_l & ~wr.clr_l; // clear last

  // data bit for each slot, pulled from its own position
  logic [NUM_EV-1:0] ev_data;

  always_comb begin
    for (int e = 0; e < NUM_EV; e++) begin
      ev_data[e] = wr.wsr_data[EV_POS[e]];
    end
  end

  // ==================================================
  // bit registers
  // ==================================================
  always_ff @(posedge rtl_clk) begin
    if (rtl_reset) begin
      event_bits <= '0;
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        for (int e = 0; e < NUM_EV; e++) begin
          // enable low freezes the bit, events included
          if (ev_en[t][e]) begin
            if (ev_src[t][e]) begin
              event_bits[t][e] <= 1'b1;  // hw event beats any strobe
            end else if (do_wr) begin
              event_bits[t][e] <= ev_data[e];
            end else if (do_set) begin
              event_bits[t][e] <= event_bits[t][e] | ev_data[e];
            end else if (do_clr) begin
              event_bits[t][e] <= event_bits[t][e] & ~ev_data[e];
            end
          end
        end
      end
    end
  end

  // software field bits are handled next door

endmodule

`default_nettype wire

//--- rtl/softint_pkg.sv
`default_nettype none

package softint_pkg;

  // ==================================================
  // register geometry
  // ==================================================
  localparam int SOFTINT_W = 17;  // full softint word

  // software-only field, written by wr/set/clr alone
  localparam int SW_LO = 1;
  localparam int SW_HI = 14;
  localparam int SW_W  = SW_HI - SW_LO + 1;

  // event bits, each with its own hardware source
  localparam int TICK_BIT  = 0;   // tick compare
  localparam int PIC_BIT   = 15;  // either perf counter wrap
  localparam int STICK_BIT = 16;  // system tick compare

  // slot order of the event bit vector per thread
  localparam int NUM_EV = 3;
  localparam int EV_POS [NUM_EV] = '{TICK_BIT, PIC_BIT, STICK_BIT};

  // ==================================================
  // types
  // ==================================================
  typedef logic [SOFTINT_W-1:0] softint_t;   // one thread's register
  typedef logic [SW_W-1:0]      sw_field_t;  // bits 14:1 only

endpackage

`default_nettype wire

//--- rtl/softint_sw_field.sv
`timescale 1ns/1ps
`default_nettype none

// software field of the softint register, bits 14:1
// one copy per thread, gated by the per-thread enable
module softint_sw_field import softint_pkg::*; #(
  parameter int NUM_THREADS = 4
) (
  input  logic                   rtl_clk,
  input  logic                   rtl_reset,
  softint_wr_if.sink             wr,
  input  logic [NUM_THREADS-1:0] sw_en_l,    // active low, per thread
  output sw_field_t              sw_field [NUM_THREADS]
);

  // ==================================================
  // strobe decode, common to all threads
  // ==================================================
  sw_field_t wr_bits;   // data bits that land in the field
  logic      do_wr;
  logic      do_set;
  logic      do_clr;

  assign wr_bits = wr.wsr_data[SW_HI:SW_LO];

  // write over set over clear
  assign do_wr  = ~wr.wr_l;
  assign do_set = wr.wr_l & ~wr.set_l;
  assign do_clr = wr.wr_l & wr.set_l & ~wr.clr_l;

  // ==================================================
  // per-thread field registers
  // ==================================================
  always_ff @(posedge rtl_clk) begin
    if (rtl_reset) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        sw_field[t] <= '0;
      end
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        // disabled thread just holds
        if (!sw_en_l[t]) begin
          if (do_wr) begin
            sw_field[t] <= wr_bits;                 // load
          end else if (do_set) begin
            sw_field[t] <= sw_field[t] | wr_bits;   // or in
          end else if (do_clr) begin
            sw_field[t] <= sw_field[t] & ~wr_bits;  // knock out
          end
        end
      end
    end
  end

  // bits 0, 15 and 16 of wsr_data belong to the event part

endmodule

`default_nettype wire

//--- rtl/softint_unit.sv
`timescale 1ns/1ps
`default_nettype none

// softint shadow model and checker, top level
// rebuilds each thread's register and compares it every cycle
module softint_unit import softint_pkg::*; #(
  parameter int NUM_THREADS = 4
) (
  input  logic                             rtl_clk,
  input  logic                             rtl_reset,

  // shared write port, active low strobes
  input  logic                             wr_sftint_l,
  input  logic                             set_sftint_l,
  input  logic                             clr_sftint_l,
  input  softint_t                         wsr_data,

  // per-thread enables
  input  logic [NUM_THREADS-1:0]           sw_en_l,    // software field, active low
  input  logic [NUM_THREADS-1:0]           tick_en,
  input  logic [NUM_THREADS-1:0]           pic_en,
  input  logic [NUM_THREADS-1:0]           stick_en,

  // per-thread hardware events
  input  logic [NUM_THREADS-1:0]           tick_int,
  input  logic [NUM_THREADS-1:0]           stick_int,
  input  logic [NUM_THREADS-1:0]           picl_wrap,
  input  logic [NUM_THREADS-1:0]           pich_wrap,

  // checking
  input  logic [NUM_THREADS*SOFTINT_W-1:0] observed,
  input  logic                             check_en,
  output logic [NUM_THREADS*SOFTINT_W-1:0] expected,
  output logic [NUM_THREADS-1:0]           mismatch
);

  // ==================================================
  // write port bundle
  // ==================================================
  softint_wr_if wr_if ();

  assign wr_if.wr_l     = wr_sftint_l;
  assign wr_if.set_l    = set_sftint_l;
  assign wr_if.clr_l    = clr_sftint_l;
  assign wr_if.wsr_data = wsr_data;

  // ==================================================
  // register parts, side by side
  // ==================================================
  sw_field_t                          sw_field [NUM_THREADS];  // bits 14:1
  logic [NUM_THREADS-1:0][NUM_EV-1:0] event_bits;              // bits 0, 15, 16

  softint_sw_field #(
    .NUM_THREADS (NUM_THREADS)
  ) i_sw_field (
    .rtl_clk   (rtl_clk),
    .rtl_reset (rtl_reset),
    .wr        (wr_if.sink),
    .sw_en_l   (sw_en_l),
    .sw_field  (sw_field)
  );

  softint_event_bits #(
    .NUM_THREADS (NUM_THREADS)
  ) i_event_bits (
    .rtl_clk    (rtl_clk),
    .rtl_reset  (rtl_reset),
    .wr         (wr_if.sink),
    .tick_en    (tick_en),
    .pic_en     (pic_en),
    .stick_en   (stick_en),
    .tick_int   (tick_int),
    .stick_int  (stick_int),
    .picl_wrap  (picl_wrap),
    .pich_wrap  (pich_wrap),
    .event_bits (event_bits)
  );

  // ==================================================
  // compare
  // ==================================================
  softint_check #(
    .NUM_THREADS (NUM_THREADS)
  ) i_check (
    .rtl_clk    (rtl_clk),
    .rtl_reset  (rtl_reset),
    .sw_field   (sw_field),
    .event_bits (event_bits),
    .observed   (observed),
    .check_en   (check_en),
    .expected   (expected),
    .mismatch   (mismatch)
  );

endmodule

`default_nettype wire

//--- rtl/softint_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// write port shared by all threads
// plain levels, sampled every rising edge, no handshake
interface softint_wr_if import softint_pkg::*; ();

  logic     wr_l;      // write, active low, highest priority
  logic     set_l;     // set, or in the data bits
  logic     clr_l;     // clear, knock out the data bits
  softint_t wsr_data;  // write data, same word for every thread

  // top drives the strobes from its ports
  modport source (
    output wr_l, set_l, clr_l, wsr_data
  );

  // register parts only look
  modport sink (
    input wr_l, set_l, clr_l, wsr_data
  );

endinterface

`default_nettype wire

//--- sim/softint_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

// watches the DUT outputs and compares them with the reference
// sampled on falling edges, halfway between updates
module softint_scoreboard import softint_pkg::*; #(
  parameter int NUM_THREADS = 4
) (
  input  logic                             rtl_clk,
  input  logic                             rtl_reset,
  input  logic [NUM_THREADS*SOFTINT_W-1:0] expected,       // DUT shadow state
  input  logic [NUM_THREADS-1:0]           mismatch,       // DUT flags
  input  logic [NUM_THREADS*SOFTINT_W-1:0] ref_expected,   // reference state
  input  logic [NUM_THREADS-1:0]           ref_mismatch,   // reference flags
  output int                               expected_errors,
  output int                               mismatch_errors,
  output int                               reset_errors,
  output int                               checks_done
);

  // ==================================================
  // bookkeeping
  // ==================================================
  int       exp_err_count = 0;
  int       mis_err_count = 0;
  int       rst_err_count = 0;
  int       check_count   = 0;
  logic     armed         = 1'b0;  // set after the first edge
  logic     after_reset   = 1'b0;  // reset was high at the last edge
  softint_t dut_word;
  softint_t ref_word;

  assign expected_errors = exp_err_count;
  assign mismatch_errors = mis_err_count;
  assign reset_errors    = rst_err_count;
  assign checks_done     = check_count;

  always @(posedge rtl_clk) begin
    armed       <= 1'b1;
    after_reset <= rtl_reset;
  end

  // ==================================================
  // compare
  // ==================================================
  always @(negedge rtl_clk) begin
    if (armed) begin
      // reset clears everything, whatever the inputs did
      if (after_reset && (expected != '0 || mismatch != '0)) begin
        rst_err_count++;
        $display("MISMATCH @%0t: state not cleared by reset, expected %h mismatch %b",
                 $time, expected, mismatch);
      end
      for (int t = 0; t < NUM_THREADS; t++) begin
        dut_word = expected[t*SOFTINT_W +: SOFTINT_W];
        ref_word = ref_expected[t*SOFTINT_W +: SOFTINT_W];
        if (dut_word !== ref_word) begin
          exp_err_count++;
          $display("MISMATCH @%0t: thread %0d expected %h, reference %h",
                   $time, t, dut_word, ref_word);
        end
        // flag belongs to the sample one cycle back
        if (mismatch[t] !== ref_mismatch[t]) begin
          mis_err_count++;
          $display("MISMATCH @%0t: thread %0d mismatch flag %b, reference %b",
                   $time, t, mismatch[t], ref_mismatch[t]);
        end
      end
      check_count++;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_softint_unit.sv
`timescale 1ns/1ps
`default_nettype none

// softint shadow model testbench
// random strobes and events per phase, reference model stepped on every rising edge
module tb_softint_unit import softint_pkg::*; ();

  // ==================================================
  // run length
  // ==================================================
  localparam int NUM_THREADS  = 4;
  localparam int RESET_CYCLES = 4;
  localparam int SW_CYCLES    = 400;  // software field only
  localparam int EV_CYCLES    = 400;  // event bits, clear bias
  localparam int IND_CYCLES   = 300;  // one thread active at a time
  localparam int MIS_CYCLES   = 400;  // flipped observed bits
  localparam int DRAIN_CYCLES = 4;
  localparam int TEST_CYCLES  = RESET_CYCLES + SW_CYCLES + EV_CYCLES + IND_CYCLES +
                                MIS_CYCLES + DRAIN_CYCLES;
  localparam int MAX_CYCLES   = TEST_CYCLES + TEST_CYCLES / 3;  // about 2000

  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // ==================================================
  // DUT signals
  // ==================================================
  logic                             rtl_clk;
  logic                             rtl_reset;
  logic                             wr_sftint_l;
  logic                             set_sftint_l;
  logic                             clr_sftint_l;
  softint_t                         wsr_data;
  logic [NUM_THREADS-1:0]           sw_en_l;
  logic [NUM_THREADS-1:0]           tick_en;
  logic [NUM_THREADS-1:0]           pic_en;
  logic [NUM_THREADS-1:0]           stick_en;
  logic [NUM_THREADS-1:0]           tick_int;
  logic [NUM_THREADS-1:0]           stick_int;
  logic [NUM_THREADS-1:0]           picl_wrap;
  logic [NUM_THREADS-1:0]           pich_wrap;
  logic [NUM_THREADS*SOFTINT_W-1:0] observed;
  logic                             check_en;
  logic [NUM_THREADS*SOFTINT_W-1:0] expected;
  logic [NUM_THREADS-1:0]           mismatch;

  // reference side
  logic [NUM_THREADS*SOFTINT_W-1:0] ref_state = '0;
  logic [NUM_THREADS-1:0]           ref_mismatch = '0;
  logic [31:0]                      lfsr_state = 32'h422c340d;
  int                               cycle_count = 0;
  int                               expected_errors;
  int                               mismatch_errors;
  int                               reset_errors;
  int                               checks_done;

  softint_unit #(
    .NUM_THREADS (NUM_THREADS)
  ) i_softint_unit (
    .rtl_clk      (rtl_clk),
    .rtl_reset    (rtl_reset),
    .wr_sftint_l  (wr_sftint_l),
    .set_sftint_l (set_sftint_l),
    .clr_sftint_l (clr_sftint_l),
    .wsr_data     (wsr_data),
    .sw_en_l      (sw_en_l),
    .tick_en      (tick_en),
    .pic_en       (pic_en),
    .stick_en     (stick_en),
    .tick_int     (tick_int),
    .stick_int    (stick_int),
    .picl_wrap    (picl_wrap),
    .pich_wrap    (pich_wrap),
    .observed     (observed),
    .check_en     (check_en),
    .expected     (expected),
    .mismatch     (mismatch)
  );

  softint_scoreboard #(
    .NUM_THREADS (NUM_THREADS)
  ) i_scoreboard (
    .rtl_clk         (rtl_clk),
    .rtl_reset       (rtl_reset),
    .expected        (expected),
    .mismatch        (mismatch),
    .ref_expected    (ref_state),
    .ref_mismatch    (ref_mismatch),
    .expected_errors (expected_errors),
    .mismatch_errors (mismatch_errors),
    .reset_errors    (reset_errors),
    .checks_done     (checks_done)
  );

  initial begin
    rtl_clk = 1'b0;
    forever #5 rtl_clk = ~rtl_clk;  // 10 ns period
  end

  // ==================================================
  // random source
  // ==================================================
  // galois lfsr, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic        taken;
    value = '0;
    for (int i = 0; i < n; i++) begin
      taken      = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (taken ? LFSR_TAPS : 32'h0);
      value      = {value[30:0], taken};
    end
    return value;
  endfunction

  function automatic logic [NUM_THREADS-1:0] mostly_ones();
    logic [31:0] a;
    logic [31:0] b;
    a = random_bits(NUM_THREADS);
    b = random_bits(NUM_THREADS);
    return a[NUM_THREADS-1:0] | b[NUM_THREADS-1:0];  // 3 in 4 high
  endfunction

  function automatic logic [NUM_THREADS-1:0] mostly_zeros();
    logic [31:0] a;
    logic [31:0] b;
    a = random_bits(NUM_THREADS);
    b = random_bits(NUM_THREADS);
    return a[NUM_THREADS-1:0] & b[NUM_THREADS-1:0];  // 1 in 4 high
  endfunction

  // ==================================================
  // reference model
  // ==================================================
  // write over set over clear, on the whole word
  function automatic softint_t apply_strobes(input softint_t old_word, input softint_t data,
                                             input logic wr_l, input logic set_l,
                                             input logic clr_l);
    softint_t result;
    if (!wr_l)       result = data;
    else if (!set_l) result = old_word | data;
    else if (!clr_l) result = old_word & ~data;
    else             result = old_word;
    return result;
  endfunction

  // one clock of all threads; events win over any strobe
  function automatic logic [NUM_THREADS*SOFTINT_W-1:0] step_reference(
    input logic [NUM_THREADS*SOFTINT_W-1:0] state
  );
    logic [NUM_THREADS*SOFTINT_W-1:0] next;
    softint_t                         old_word;
    softint_t                         op_word;
    softint_t                         new_word;
    next = state;
    for (int t = 0; t < NUM_THREADS; t++) begin
      old_word = state[t*SOFTINT_W +: SOFTINT_W];
      op_word  = apply_strobes(old_word, wsr_data, wr_sftint_l, set_sftint_l, clr_sftint_l);
      new_word = old_word;  // disabled parts hold
      if (!sw_en_l[t]) new_word[SW_HI:SW_LO] = op_word[SW_HI:SW_LO];
      if (tick_en[t])  new_word[TICK_BIT]  = tick_int[t] | op_word[TICK_BIT];
      if (stick_en[t]) new_word[STICK_BIT] = stick_int[t] | op_word[STICK_BIT];
      if (pic_en[t])   new_word[PIC_BIT]   = picl_wrap[t] | pich_wrap[t] | op_word[PIC_BIT];
      next[t*SOFTINT_W +: SOFTINT_W] = new_word;
    end
    return next;
  endfunction

  always @(posedge rtl_clk) begin
    if (rtl_reset) begin
      ref_state    <= '0;
      ref_mismatch <= '0;
    end else begin
      ref_state <= step_reference(ref_state);
      for (int t = 0; t < NUM_THREADS; t++) begin
        // compared against the state before this edge
        ref_mismatch[t] <= check_en &&
                           (observed[t*SOFTINT_W +: SOFTINT_W] !=
                            ref_state[t*SOFTINT_W +: SOFTINT_W]);
      end
    end
  end

  // ==================================================
  // stimulus tasks, called on falling edges
  // ==================================================
  task automatic drive_strobes(input logic bias_clear);
    logic [31:0] r;
    r            = random_bits(3);
    wr_sftint_l  = r[0];
    set_sftint_l = r[1];
    clr_sftint_l = r[2];
    r            = random_bits(SOFTINT_W);
    wsr_data     = r[SOFTINT_W-1:0];
    if (bias_clear) begin
      r = random_bits(2);
      if (r[1:0] == 2'b00) begin  // clear everything, races the events
        wr_sftint_l  = 1'b1;
        set_sftint_l = 1'b1;
        clr_sftint_l = 1'b0;
        wsr_data     = '1;
      end
    end
  endtask

  // only threads in active get enables; events hit every thread
  task automatic drive_events(input logic [NUM_THREADS-1:0] active);
    sw_en_l   = ~mostly_ones() | ~active;
    tick_en   = mostly_ones() & active;
    pic_en    = mostly_ones() & active;
    stick_en  = mostly_ones() & active;
    tick_int  = mostly_zeros();
    stick_int = mostly_zeros();
    picl_wrap = mostly_zeros();
    pich_wrap = mostly_zeros();
  endtask

  task automatic drive_observed(input logic flip, input logic check);
    logic [31:0] r;
    int          thread_sel;
    int          bit_sel;
    observed = ref_state;
    check_en = check;
    if (flip) begin
      r          = random_bits(2);
      thread_sel = r % NUM_THREADS;
      r          = random_bits(5);
      bit_sel    = r % SOFTINT_W;
      observed[thread_sel*SOFTINT_W + bit_sel] = ~observed[thread_sel*SOFTINT_W + bit_sel];
    end
  endtask

  task automatic drive_idle();
    wr_sftint_l  = 1'b1;
    set_sftint_l = 1'b1;
    clr_sftint_l = 1'b1;
    drive_events('0);
    tick_int     = '0;
    stick_int    = '0;
    picl_wrap    = '0;
    pich_wrap    = '0;
    drive_observed(1'b0, 1'b1);
  endtask

  // ==================================================
  // phases
  // ==================================================
  initial begin
    logic [31:0]            r;
    logic [NUM_THREADS-1:0] active;
    rtl_reset    = 1'b1;
    wr_sftint_l  = 1'b1;
    set_sftint_l = 1'b1;
    clr_sftint_l = 1'b1;
    wsr_data     = '0;
    sw_en_l      = '1;
    tick_en      = '0;
    pic_en       = '0;
    stick_en     = '0;
    tick_int     = '0;
    stick_int    = '0;
    picl_wrap    = '0;
    pich_wrap    = '0;
    observed     = '0;
    check_en     = 1'b0;

    // reset with busy inputs, nothing may leak through
    repeat (RESET_CYCLES) begin
      @(negedge rtl_clk);
      drive_strobes(1'b0);
      drive_events('1);
      drive_observed(1'b1, 1'b1);
    end
    rtl_reset = 1'b0;

    for (int i = 0; i < SW_CYCLES; i++) begin
      drive_strobes(1'b0);
      drive_events('1);
      tick_en  = '0;  // software field alone
      pic_en   = '0;
      stick_en = '0;
      drive_observed(1'b0, 1'b1);
      @(negedge rtl_clk);
    end

    for (int i = 0; i < EV_CYCLES; i++) begin
      drive_strobes(1'b1);
      drive_events('1);
      drive_observed(1'b0, 1'b1);
      @(negedge rtl_clk);
    end

    for (int i = 0; i < IND_CYCLES; i++) begin
      active                                   = '0;
      active[(i / 25) % NUM_THREADS]           = 1'b1;  // rotate every 25 cycles
      drive_strobes(1'b1);
      drive_events(active);
      drive_observed(1'b0, 1'b1);
      @(negedge rtl_clk);
    end

    for (int i = 0; i < MIS_CYCLES; i++) begin
      drive_strobes(1'b0);
      drive_events('1);
      if (i < MIS_CYCLES / 2) begin
        r = random_bits(2);
        drive_observed(r[1:0] == 2'b00, 1'b1);
      end else if (i < 3 * MIS_CYCLES / 4) begin
        r = random_bits(1);
        drive_observed(1'b1, r[0]);
      end else begin
        drive_observed(1'b1, 1'b0);  // check off
      end
      @(negedge rtl_clk);
    end

    repeat (DRAIN_CYCLES) begin
      drive_idle();
      @(negedge rtl_clk);
    end
    @(posedge rtl_clk);  // scoreboard counts settle on falling edges

    $display("checks %0d, errors: expected %0d, mismatch %0d, reset %0d",
             checks_done, expected_errors, mismatch_errors, reset_errors);
    if (checks_done > 0 && expected_errors + mismatch_errors + reset_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge rtl_clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/softint_pkg.sv
rtl/softint_wr_if.sv
rtl/softint_sw_field.sv
rtl/softint_event_bits.sv
rtl/softint_check.sv
rtl/softint_unit.sv
sim/softint_scoreboard.sv
sim/tb_softint_unit.sv
